/* src.f */
+incdir+hw
hw/lrelu_pkg.sv
hw/lrelu_beat_if.sv
hw/lrelu_config_store.sv
hw/lrelu_datapath.sv
hw/lrelu_credit_buffer.sv
hw/lrelu_engine.sv
sim/lrelu_engine_properties.sv
sim/lrelu_engine_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the lrelu_engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module lrelu_engine_tb -f src.f -Mdir obj_dir -o lrelu_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/lrelu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "No errors" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

/* sim/lrelu_engine_tb.sv */
`timescale 1ns/100ps
`include "lrelu_macros.svh"

module lrelu_engine_tb;

  import lrelu_pkg::*;

  localparam int LANES = `LRELU_LANES;
  localparam int UNITS = `LRELU_UNITS;
  localparam int GROUPS = `LRELU_GROUPS;
  localparam int DEPTH = `LRELU_BUF_DEPTH;
  localparam int OUT_MAX = 2 ** (`LRELU_OUT_W - 1) - 1;
  localparam int OUT_MIN = -(2 ** (`LRELU_OUT_W - 1));
  // beats per test set the watchdog budget
  localparam int CONFIG_BEATS = 8;
  localparam int AFFINE_BEATS = 16;
  localparam int LEAKY_BEATS = 16;
  localparam int TOTAL_BEATS = CONFIG_BEATS + AFFINE_BEATS + LEAKY_BEATS + DEPTH;

  logic      clk;
  logic      rst;
  logic      s_valid;
  logic      s_last;
  logic      s_lrelu;
  in_beat_t  s_data;
  logic      s_credit;
  logic      m_valid;
  logic      m_last;
  out_beat_t m_data;
  logic      m_credit;
  logic      config_clear;
  logic      config_valid;
  cfg_word_t config_scale;
  cfg_word_t config_bias;
  logic      config_full;

  logic [31:0] rnd_state;
  cfg_word_t   tb_scale [GROUPS];
  cfg_word_t   tb_bias [GROUPS];
  int          cfg_count;
  int          up_credits;
  int          credit_returns;
  int          sent_count;
  int          rx_count;
  int          error_count;
  out_beat_t   exp_data_q [$];
  logic        exp_last_q [$];

  lrelu_engine i_lrelu_engine (
    .clk          (clk),
    .rst          (rst),
    .s_valid      (s_valid),
    .s_last       (s_last),
    .s_lrelu      (s_lrelu),
    .s_data       (s_data),
    .s_credit     (s_credit),
    .m_valid      (m_valid),
    .m_last       (m_last),
    .m_data       (m_data),
    .m_credit     (m_credit),
    .config_clear (config_clear),
    .config_valid (config_valid),
    .config_scale (config_scale),
    .config_bias  (config_bias),
    .config_full  (config_full)
  );

  bind lrelu_credit_buffer lrelu_engine_properties i_properties (
    .clk        (clk),
    .rst        (rst),
    .push       (push),
    .fifo_full  (fifo_full),
    .m_valid    (m_valid),
    .s_credit   (s_credit),
    .credit_cnt (credit_cnt)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rnd_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rnd_state = x;
    return x;
  endfunction

  // narrow words stay in byte range while others use all 16 bits
  function automatic in_beat_t make_beat(input bit narrow);
    in_beat_t    beat;
    logic [31:0] r;
    for (int l = 0; l < LANES; l++) begin
      r = next_random();
      if (narrow) begin
        beat[l] = in_word_t'($signed(r[7:0]));
      end else begin
        beat[l] = r[15:0];
      end
    end
    return beat;
  endfunction

  // scale, optional 1/8 slope on negatives, bias, clamp to a byte
  function automatic out_beat_t model_beat(input in_beat_t data, input logic lrelu);
    out_beat_t res;
    int        v;
    for (int l = 0; l < LANES; l++) begin
      v = int'(data[l]) * int'(tb_scale[l / UNITS]);
      v = v >>> `LRELU_SCALE_FRAC;
      if (lrelu && v < 0) begin
        v = v >>> `LRELU_ALPHA_SHIFT;
      end
      v = v + int'(tb_bias[l / UNITS]);
      if (v > OUT_MAX) begin
        v = OUT_MAX;
      end else if (v < OUT_MIN) begin
        v = OUT_MIN;
      end
      res[l] = out_word_t'(v);
    end
    return res;
  endfunction

  task automatic compare_beat(input string name, input out_beat_t got, input out_beat_t exp);
    for (int l = 0; l < LANES; l++) begin
      if (got[l] !== exp[l]) begin
        $display("Error: %s lane %0d got %h expected %h", name, l, got[l], exp[l]);
        error_count++;
        return;
      end
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    $display("%s finished with %0d errors", name, error_count - start_errors);
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst && s_credit) begin
      up_credits++;
      credit_returns++;
    end
    if (!rst && m_valid) begin
      if (exp_data_q.size() == 0) begin
        $display("m_valid asserted while no beat was outstanding");
        error_count++;
      end else begin
        compare_beat("m_data", m_data, exp_data_q.pop_front());
        compare_bit("m_last", m_last, exp_last_q.pop_front());
        rx_count++;
      end
    end
  end

  task automatic clear_config();
    @(posedge clk);
    #10;
    config_clear = 1'b1;
    @(posedge clk);
    #10;
    config_clear = 1'b0;
    cfg_count = 0;
  endtask

  task automatic write_config(input cfg_word_t scale, input cfg_word_t bias);
    @(posedge clk);
    #10;
    config_valid = 1'b1;
    config_scale = scale;
    config_bias  = bias;
    @(posedge clk);
    #10;
    config_valid = 1'b0;
    // writes past a full table are dropped
    if (cfg_count < GROUPS) begin
      tb_scale[cfg_count] = scale;
      tb_bias[cfg_count]  = bias;
      cfg_count++;
    end
  endtask

  task automatic load_config(input bit positive);
    logic [31:0] r;
    cfg_word_t   scale;
    clear_config();
    for (int g = 0; g < GROUPS; g++) begin
      r = next_random();
      scale = positive ? cfg_word_t'({1'b0, r[6:1], 1'b1}) : cfg_word_t'(r[7:0]);
      write_config(scale, cfg_word_t'(r[15:8]));
    end
  endtask

  task automatic grant_credits(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #10;
      m_credit = 1'b1;
    end
    @(posedge clk);
    #10;
    m_credit = 1'b0;
  endtask

  // holds s_valid low while upstream has no credit
  task automatic send_beat(input in_beat_t data, input logic last, input logic lrelu);
    if (up_credits == 0) begin
      @(posedge clk);
      #10;
      s_valid = 1'b0;
      while (up_credits == 0) begin
        @(negedge clk);
      end
    end
    @(posedge clk);
    #10;
    s_valid = 1'b1;
    s_last  = last;
    s_lrelu = lrelu;
    s_data  = data;
    up_credits--;
    sent_count++;
    exp_data_q.push_back(model_beat(data, lrelu));
    exp_last_q.push_back(last);
  endtask

  task automatic end_burst();
    @(posedge clk);
    #10;
    s_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_data_q.size() != 0 || up_credits != DEPTH) begin
      @(negedge clk);
    end
  endtask

  task automatic run_beats(input int n, input logic lrelu);
    logic [31:0] r;
    grant_credits(n);
    for (int i = 0; i < n; i++) begin
      r = next_random();
      send_beat(make_beat(i % 2 == 1), r[0], lrelu);
    end
    end_burst();
    wait_drain();
  endtask

  task automatic test_reset();
    int start;
    start = error_count;
    compare_bit("m_valid", m_valid, 1'b0);
    compare_bit("s_credit", s_credit, 1'b0);
    compare_bit("config_full", config_full, 1'b0);
    report_test("test_reset", start);
  endtask

  task automatic test_config();
    int          start;
    logic [31:0] r;
    start = error_count;
    clear_config();
    for (int g = 0; g < GROUPS; g++) begin
      compare_bit("config_full", config_full, 1'b0);
      r = next_random();
      write_config(cfg_word_t'(r[7:0]), cfg_word_t'(r[15:8]));
    end
    compare_bit("config_full", config_full, 1'b1);
    // one write too many leaves the table unchanged
    r = next_random();
    write_config(cfg_word_t'(r[7:0]), cfg_word_t'(r[15:8]));
    compare_bit("config_full", config_full, 1'b1);
    run_beats(CONFIG_BEATS / 2, 1'b0);
    clear_config();
    compare_bit("config_full", config_full, 1'b0);
    load_config(1'b0);
    compare_bit("config_full", config_full, 1'b1);
    run_beats(CONFIG_BEATS / 2, 1'b0);
    report_test("test_config", start);
  endtask

  task automatic test_affine();
    int start;
    start = error_count;
    load_config(1'b0);
    run_beats(AFFINE_BEATS, 1'b0);
    report_test("test_affine", start);
  endtask

  // positive scales keep negative words negative through the product
  task automatic test_leaky();
    int start;
    start = error_count;
    load_config(1'b1);
    run_beats(LEAKY_BEATS, 1'b1);
    report_test("test_leaky", start);
  endtask

  task automatic test_backpressure();
    int start;
    int rx_before;
    int ret_before;
    start      = error_count;
    rx_before  = rx_count;
    ret_before = credit_returns;
    for (int i = 0; i < DEPTH; i++) begin
      send_beat(make_beat(1'b1), i == DEPTH - 1, 1'b0);
    end
    end_burst();
    repeat (20) @(negedge clk);
    if (rx_count != rx_before) begin
      $display("beats left the engine without any downstream credit");
      error_count++;
    end
    grant_credits(3);
    while (rx_count < rx_before + 3) begin
      @(negedge clk);
    end
    repeat (10) @(negedge clk);
    if (rx_count != rx_before + 3) begin
      $display("more beats left than downstream credits were granted");
      error_count++;
    end
    grant_credits(DEPTH - 3);
    wait_drain();
    if (credit_returns - ret_before != DEPTH) begin
      $display("upstream credit returns do not match the beats sent");
      error_count++;
    end
    report_test("test_backpressure", start);
  endtask

  initial begin
    repeat (TOTAL_BEATS * 20 + 2000) @(posedge clk);
    $display("watchdog timeout, the tests did not finish in time");
    $display("Errors found");
    $finish;
  end

  initial begin
    clk            = 1'b0;
    rst            = 1'b1;
    s_valid        = 1'b0;
    s_last         = 1'b0;
    s_lrelu        = 1'b0;
    s_data         = '0;
    m_credit       = 1'b0;
    config_clear   = 1'b0;
    config_valid   = 1'b0;
    config_scale   = '0;
    config_bias    = '0;
    rnd_state      = 32'h22a45f56;
    cfg_count      = 0;
    up_credits     = DEPTH;
    credit_returns = 0;
    sent_count     = 0;
    rx_count       = 0;
    error_count    = 0;
    repeat (10) @(posedge clk);
    #10;
    rst = 1'b0;
    test_reset();
    test_config();
    test_affine();
    test_leaky();
    test_backpressure();
    repeat (5) @(posedge clk);
    $display("beats sent %0d, received %0d, errors %0d", sent_count, rx_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* sim/lrelu_engine_properties.sv */
`timescale 1ns/100ps
`include "lrelu_macros.svh"

// checks on the output buffer, bound into lrelu_credit_buffer
module lrelu_engine_properties #(
  parameter int CNT_W = $clog2(`LRELU_BUF_DEPTH + 1) + 1
) (
  input logic             clk,
  input logic             rst,
  input logic             push,
  input logic             fifo_full,
  input logic             m_valid,
  input logic             s_credit,
  input logic [CNT_W-1:0] credit_cnt
);

  // upstream credits keep the fifo from overflowing
  a_no_write_when_full: assert property (
    @(posedge clk) disable iff (rst) !(push && fifo_full)
  ) else $error("fifo written while full");

  // a beat on m_valid always holds a downstream credit
  a_credit_held: assert property (
    @(posedge clk) disable iff (rst) m_valid |-> (credit_cnt != '0)
  ) else $error("m_valid asserted with zero downstream credits");

  // synchronous reset forces both strobes low
  a_reset_quiet: assert property (
    @(posedge clk) rst |=> (!m_valid && !s_credit)
  ) else $error("m_valid or s_credit high during reset");

endmodule

/* hw/lrelu_engine.sv */
`timescale 1ns/100ps

module lrelu_engine (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 s_valid,
  input  logic                 s_last,
  input  logic                 s_lrelu,
  input  lrelu_pkg::in_beat_t  s_data,
  output logic                 s_credit,
  output logic                 m_valid,
  output logic                 m_last,
  output lrelu_pkg::out_beat_t m_data,
  input  logic                 m_credit,
  input  logic                 config_clear,
  input  logic                 config_valid,
  input  lrelu_pkg::cfg_word_t config_scale,
  input  lrelu_pkg::cfg_word_t config_bias,
  output logic                 config_full
);

  import lrelu_pkg::*;

  cfg_table_t cfg_table;

  lrelu_beat_if beat ();

  // scale and bias per group
  lrelu_config_store i_config_store (
    .clk          (clk),
    .rst          (rst),
    .config_clear (config_clear),
    .config_valid (config_valid),
    .config_scale (config_scale),
    .config_bias  (config_bias),
    .cfg_table    (cfg_table),
    .config_full  (config_full)
  );

  // three-cycle arithmetic
  lrelu_datapath i_datapath (
    .clk       (clk),
    .rst       (rst),
    .s_valid   (s_valid),
    .s_last    (s_last),
    .s_lrelu   (s_lrelu),
    .s_data    (s_data),
    .cfg_table (cfg_table),
    .beat      (beat.src)
  );

  lrelu_credit_buffer i_credit_buffer (
    .clk      (clk),
    .rst      (rst),
    .beat     (beat.dst),
    .m_credit (m_credit),
    .m_valid  (m_valid),
    .m_last   (m_last),
    .s_credit (s_credit),
    .m_data   (m_data)
  );

endmodule

/* hw/lrelu_credit_buffer.sv */
`timescale 1ns/100ps
`include "lrelu_macros.svh"

module lrelu_credit_buffer (
  input  logic                 clk,
  input  logic                 rst,
  lrelu_beat_if.dst            beat,
  input  logic                 m_credit,
  output logic                 m_valid,
  output logic                 m_last,
  output logic                 s_credit,
  output lrelu_pkg::out_beat_t m_data
);

  import lrelu_pkg::*;

  localparam int DEPTH = `LRELU_BUF_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1) + 1;

  out_beat_t        data_mem [DEPTH];
  logic             last_mem [DEPTH];
  logic [PTR_W:0]   wr_ptr;
  logic [PTR_W:0]   rd_ptr;
  logic [CNT_W-1:0] credit_cnt;
  logic             push;
  logic             pop;
  logic             fifo_full;
  logic             fifo_empty;
  logic             credit_free;

  assign push       = beat.valid;
  assign fifo_empty = (wr_ptr == rd_ptr);
  // wrap bits differ, index bits equal
  assign fifo_full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                      (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

  // the beat now on m_valid still holds its credit in the count
  assign credit_free = credit_cnt > CNT_W'(m_valid);
  assign pop         = !fifo_empty && credit_free;

  // fifo storage
  always_ff @(posedge clk) begin
    if (push && !fifo_full) begin
      data_mem[wr_ptr[PTR_W-1:0]] <= beat.data;
      last_mem[wr_ptr[PTR_W-1:0]] <= beat.last;
    end
  end

  // pointers, downstream credits, output strobes
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      credit_cnt <= '0;
      m_valid    <= 1'b0;
      s_credit   <= 1'b0;
    end else begin
      if (push && !fifo_full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      credit_cnt <= credit_cnt + CNT_W'(m_credit) - CNT_W'(m_valid);
      m_valid    <= pop;
      // credit goes back upstream as the beat leaves
      s_credit   <= pop;
    end
  end

  // output payload
  always_ff @(posedge clk) begin
    if (pop) begin
      m_data <= data_mem[rd_ptr[PTR_W-1:0]];
      m_last <= last_mem[rd_ptr[PTR_W-1:0]];
    end
  end

endmodule

/* hw/lrelu_datapath.sv */
`timescale 1ns/100ps
`include "lrelu_macros.svh"

module lrelu_datapath (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  s_valid,
  input  logic                  s_last,
  input  logic                  s_lrelu,
  input  lrelu_pkg::in_beat_t   s_data,
  input  lrelu_pkg::cfg_table_t cfg_table,
  lrelu_beat_if.src             beat
);

  import lrelu_pkg::*;

  localparam int UNITS = `LRELU_UNITS;
  localparam int LANES = `LRELU_LANES;
  localparam int SCALE_FRAC = `LRELU_SCALE_FRAC;
  localparam int ALPHA_SHIFT = `LRELU_ALPHA_SHIFT;
  // full product width, one more bit for the bias add
  localparam int PROD_W = `LRELU_IN_W + `LRELU_CFG_W;
  localparam int SUM_W = PROD_W + 1;
  localparam int OUT_MAX = 2 ** (`LRELU_OUT_W - 1) - 1;
  localparam int OUT_MIN = -(2 ** (`LRELU_OUT_W - 1));

  side_t                    side_q [3];
  logic signed [PROD_W-1:0] scaled_q [LANES];
  logic signed [PROD_W-1:0] sloped_q [LANES];
  out_word_t                data_q [LANES];

  // sideband, one register per stage
  always_ff @(posedge clk) begin
    side_q[0] <= '{valid: s_valid, last: s_last, lrelu: s_lrelu};
    side_q[1] <= side_q[0];
    side_q[2] <= side_q[1];
    if (rst) begin
      for (int i = 0; i < 3; i++) begin
        side_q[i].valid <= 1'b0;
      end
    end
  end

  for (genvar l = 0; l < LANES; l++) begin : g_lane
    // lanes are grouped UNITS at a time
    localparam int G = l / UNITS;

    in_word_t                word;
    cfg_word_t                scale;
    cfg_word_t                bias;
    logic signed [PROD_W-1:0] product;
    logic signed [SUM_W-1:0]  sum;

    assign word    = s_data[l];
    assign scale   = cfg_table[G].scale;
    assign bias    = cfg_table[G].bias;
    assign product = word * scale;
    assign sum     = sloped_q[l] + bias;

    // stage 1, scale
    always_ff @(posedge clk) begin
      scaled_q[l] <= product >>> SCALE_FRAC;
    end

    // stage 2, leaky slope on negative values
    always_ff @(posedge clk) begin
      if (side_q[0].lrelu && scaled_q[l][PROD_W-1]) begin
        sloped_q[l] <= scaled_q[l] >>> ALPHA_SHIFT;
      end else begin
        sloped_q[l] <= scaled_q[l];
      end
    end

    // stage 3, bias and clamp to a signed byte
    always_ff @(posedge clk) begin
      if (sum > OUT_MAX) begin
        data_q[l] <= out_word_t'(OUT_MAX);
      end else if (sum < OUT_MIN) begin
        data_q[l] <= out_word_t'(OUT_MIN);
      end else begin
        data_q[l] <= out_word_t'(sum);
      end
    end

    assign beat.data[l] = data_q[l];
  end

  assign beat.valid = side_q[2].valid;
  assign beat.last  = side_q[2].last;

endmodule

/* hw/lrelu_config_store.sv */
`timescale 1ns/100ps
`include "lrelu_macros.svh"

module lrelu_config_store (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   config_clear,
  input  logic                   config_valid,
  input  lrelu_pkg::cfg_word_t   config_scale,
  input  lrelu_pkg::cfg_word_t   config_bias,
  output lrelu_pkg::cfg_table_t  cfg_table,
  output logic                   config_full
);

  import lrelu_pkg::*;

  localparam int GROUPS = `LRELU_GROUPS;
  localparam int IDX_W = $clog2(GROUPS + 1);

  logic [IDX_W-1:0] wr_idx;
  logic             wr_en;

  // clear beats a write in the same cycle
  assign wr_en = config_valid && !config_full && !config_clear && !rst;

  // write counter and full flag
  always_ff @(posedge clk) begin
    if (rst || config_clear) begin
      wr_idx      <= '0;
      config_full <= 1'b0;
    end else if (wr_en) begin
      wr_idx <= wr_idx + 1'b1;
      if (wr_idx == IDX_W'(GROUPS - 1)) begin
        config_full <= 1'b1;
      end
    end
  end

  // table contents survive a clear
  always_ff @(posedge clk) begin
    if (wr_en) begin
      cfg_table[wr_idx].scale <= config_scale;
      cfg_table[wr_idx].bias  <= config_bias;
    end
  end

endmodule

/* hw/lrelu_beat_if.sv */
`timescale 1ns/100ps

// one processed beat, datapath to output buffer
interface lrelu_beat_if;

  logic valid;
  logic last;
  lrelu_pkg::out_beat_t data;

  // no ready, the credit scheme guarantees room
  modport src (
    output valid,
    output last,
    output data
  );

  modport dst (
    input valid,
    input last,
    input data
  );

endinterface

/* hw/lrelu_pkg.sv */
`include "lrelu_macros.svh"

package lrelu_pkg;

  // accumulator word in, saturated byte out
  typedef logic signed [`LRELU_IN_W-1:0] in_word_t;
  typedef logic signed [`LRELU_OUT_W-1:0] out_word_t;

  // lane l sits at bits [l*W +: W]
  typedef in_word_t [`LRELU_LANES-1:0] in_beat_t;
  typedef out_word_t [`LRELU_LANES-1:0] out_beat_t;

  // per-group configuration
  typedef logic signed [`LRELU_CFG_W-1:0] cfg_word_t;

  typedef struct packed {
    cfg_word_t scale;
    cfg_word_t bias;
  } group_cfg_t;

  typedef group_cfg_t [`LRELU_GROUPS-1:0] cfg_table_t;

  // control bits that ride along with each beat
  typedef struct packed {
    logic valid;
    logic last;
    logic lrelu;
  } side_t;

endpackage

/* hw/lrelu_macros.svh */
`ifndef LRELU_MACROS_SVH
`define LRELU_MACROS_SVH

// beat geometry
`define LRELU_UNITS 4
`define LRELU_GROUPS 2
`define LRELU_LANES 8

// word widths
`define LRELU_IN_W 16
`define LRELU_OUT_W 8
`define LRELU_CFG_W 8

// fixed-point shifts, slope is 1/8
`define LRELU_SCALE_FRAC 4
`define LRELU_ALPHA_SHIFT 3

// output fifo entries, also the upstream's starting credits
`define LRELU_BUF_DEPTH 8

`endif
